//--- pointPool.f
source/pointPoolPkg.sv
source/startDebounce.sv
source/runControl.sv
source/pointBuffer.sv
source/taskDispatcher.sv
source/poolCore.sv
source/resultCollector.sv
source/pointPoolTop.sv
test/pointPoolTb.sv

//--- source/pointBuffer.sv
// On-chip buffer for one frame of features and one frame of neighbor maps
// One shared write port, one map read port, one feature read port per core

`timescale 1ns/1ns

module pointBuffer (
    input  logic                                    clk,
    input  pointPoolPkg::bufWrite_t                 bufWr,
    input  logic                                    mapRdEn,
    input  logic [pointPoolPkg::MAP_ADDR_WIDTH-1:0] mapRdAddr,
    output pointPoolPkg::mapWord_t                  mapRdDat,
    input  pointPoolPkg::featRead_t                 featRd [pointPoolPkg::POOL_CORE],
    output pointPoolPkg::featWord_t                 featRdDat [pointPoolPkg::POOL_CORE]
);

    pointPoolPkg::featWord_t featMem [pointPoolPkg::FEAT_DEPTH];
    pointPoolPkg::mapWord_t  mapMem  [pointPoolPkg::MAP_DEPTH];

    // Writes
    always_ff @(posedge clk) begin
        if (bufWr.en && !bufWr.selMap)
            featMem[bufWr.addr] <= bufWr.dat;
        if (bufWr.en && bufWr.selMap)
            mapMem[bufWr.addr] <= bufWr.dat;
    end

    // Registered reads, data holds until the next enable
    always_ff @(posedge clk) begin
        if (mapRdEn)
            mapRdDat <= mapMem[mapRdAddr];
        for (int c = 0; c < pointPoolPkg::POOL_CORE; c++) begin
            if (featRd[c].en)
                featRdDat[c] <= featMem[featRd[c].idx];
        end
    end

endmodule

//--- source/pointPoolPkg.sv
// Shared sizes, bus structs and run states of the point pooling accelerator
// Every RTL file refers to these by scoped names

package pointPoolPkg;

    // ================================================
    // Sizes
    // ================================================
    localparam int ACT_WIDTH       = 8;
    localparam int NUM_LANE        = 4;
    localparam int PORT_WIDTH      = NUM_LANE * ACT_WIDTH;
    localparam int FEAT_DEPTH      = 64;
    localparam int MAP_DEPTH       = 64;
    localparam int IDX_WIDTH       = $clog2(FEAT_DEPTH);
    localparam int MAP_ADDR_WIDTH  = $clog2(MAP_DEPTH);
    localparam int CNT_WIDTH       = $clog2(MAP_DEPTH + 1);
    localparam int NUM_NEIGHBOR    = 4;
    localparam int FIELD_WIDTH     = 8;
    localparam int STEP_WIDTH      = $clog2(NUM_NEIGHBOR + 2);
    localparam int POOL_CORE       = 4;
    localparam int CORE_WIDTH      = $clog2(POOL_CORE);
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEB_WIDTH       = $clog2(DEBOUNCE_CYCLES);

    // ================================================
    // Data words and bus structs
    // ================================================
    typedef logic [NUM_LANE-1:0][ACT_WIDTH-1:0] featWord_t;

    // Only the low IDX_WIDTH bits of each field address the feature memory
    typedef logic [NUM_NEIGHBOR-1:0][FIELD_WIDTH-1:0] mapWord_t;

    typedef struct packed {
        logic [PORT_WIDTH-1:0] dat;
        logic                  last;
    } padBeat_t;

    typedef struct packed {
        logic                  en;
        logic                  selMap;
        logic [IDX_WIDTH-1:0]  addr;
        logic [PORT_WIDTH-1:0] dat;
    } bufWrite_t;

    typedef struct packed {
        logic                 en;
        logic [IDX_WIDTH-1:0] idx;
    } featRead_t;

    typedef enum logic [2:0] {
        Idle,
        LoadFeat,
        LoadMap,
        Pool,
        Done
    } runState_t;

endpackage

//--- source/pointPoolTop.sv
// Point pooling accelerator top level
// Shared pad bus turned around by datOE, start button in, finish pulse out

`timescale 1ns/1ns

module pointPoolTop (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                startPulse,
    inout  logic [pointPoolPkg::PORT_WIDTH-1:0] padDat,
    inout  logic                                padDatVld,
    inout  logic                                padDatLast,
    inout  logic                                padDatRdy,
    output logic                                datOE,
    output logic                                netFnh
);

    logic                                    startFire;
    logic                                    inRdy;
    logic                                    outVld;
    logic                                    poolGo;
    logic                                    poolDone;
    logic                                    mapRdEn;
    logic [pointPoolPkg::CNT_WIDTH-1:0]      numTasks;
    logic [pointPoolPkg::MAP_ADDR_WIDTH-1:0] mapRdAddr;
    logic [pointPoolPkg::POOL_CORE-1:0]      taskVld;
    logic [pointPoolPkg::POOL_CORE-1:0]      taskRdy;
    logic [pointPoolPkg::POOL_CORE-1:0]      resVld;
    logic [pointPoolPkg::POOL_CORE-1:0]      resRdy;
    pointPoolPkg::padBeat_t                  inBeat;
    pointPoolPkg::padBeat_t                  outBeat;
    pointPoolPkg::bufWrite_t                 bufWr;
    pointPoolPkg::mapWord_t                  mapRdDat;
    pointPoolPkg::mapWord_t                  taskDat;
    pointPoolPkg::featRead_t                 featRd    [pointPoolPkg::POOL_CORE];
    pointPoolPkg::featWord_t                 featRdDat [pointPoolPkg::POOL_CORE];
    pointPoolPkg::featWord_t                 res       [pointPoolPkg::POOL_CORE];

    // ================================================
    // Pad turnaround
    // ================================================
    assign padDat     = datOE ? outBeat.dat  : 'z;
    assign padDatVld  = datOE ? outVld       : 1'bz;
    assign padDatLast = datOE ? outBeat.last : 1'bz;
    assign padDatRdy  = datOE ? 1'bz         : inRdy;

    assign inBeat.dat  = padDat;
    assign inBeat.last = padDatLast;

    // ================================================
    // Instances
    // ================================================
    startDebounce uDebounce (
        .clk       (clk),
        .arstN     (arstN),
        .button    (startPulse),
        .startFire (startFire)
    );

    runControl uControl (
        .clk       (clk),
        .arstN     (arstN),
        .startFire (startFire),
        .inBeat    (inBeat),
        .inVld     (padDatVld),
        .inRdy     (inRdy),
        .datOE     (datOE),
        .bufWr     (bufWr),
        .numTasks  (numTasks),
        .poolGo    (poolGo),
        .poolDone  (poolDone),
        .netFnh    (netFnh)
    );

    pointBuffer uBuffer (
        .clk       (clk),
        .bufWr     (bufWr),
        .mapRdEn   (mapRdEn),
        .mapRdAddr (mapRdAddr),
        .mapRdDat  (mapRdDat),
        .featRd    (featRd),
        .featRdDat (featRdDat)
    );

    taskDispatcher uDispatch (
        .clk       (clk),
        .arstN     (arstN),
        .poolGo    (poolGo),
        .numTasks  (numTasks),
        .mapRdEn   (mapRdEn),
        .mapRdAddr (mapRdAddr),
        .mapRdDat  (mapRdDat),
        .taskDat   (taskDat),
        .taskVld   (taskVld),
        .taskRdy   (taskRdy)
    );

    for (genvar g = 0; g < pointPoolPkg::POOL_CORE; g++) begin : genCore
        poolCore uCore (
            .clk       (clk),
            .arstN     (arstN),
            .taskDat   (taskDat),
            .taskVld   (taskVld[g]),
            .taskRdy   (taskRdy[g]),
            .featRd    (featRd[g]),
            .featRdDat (featRdDat[g]),
            .res       (res[g]),
            .resVld    (resVld[g]),
            .resRdy    (resRdy[g])
        );
    end

    resultCollector uCollect (
        .clk       (clk),
        .arstN     (arstN),
        .numTasks  (numTasks),
        .res       (res),
        .resVld    (resVld),
        .resRdy    (resRdy),
        .outBeat   (outBeat),
        .outVld    (outVld),
        .outRdy    (padDatRdy),
        .poolDone  (poolDone)
    );

endmodule

//--- source/poolCore.sv
// Pooling core
// Takes one map word, reads its neighbor features one per cycle and
// keeps the lane-wise maximum until the collector takes it

`timescale 1ns/1ns

module poolCore (
    input  logic                    clk,
    input  logic                    arstN,
    input  pointPoolPkg::mapWord_t  taskDat,
    input  logic                    taskVld,
    output logic                    taskRdy,
    output pointPoolPkg::featRead_t featRd,
    input  pointPoolPkg::featWord_t featRdDat,
    output pointPoolPkg::featWord_t res,
    output logic                    resVld,
    input  logic                    resRdy
);

    logic                                busy;
    logic [pointPoolPkg::STEP_WIDTH-1:0] step;
    pointPoolPkg::mapWord_t              idxReg;
    pointPoolPkg::featWord_t             acc;

    assign taskRdy    = ~busy;
    assign featRd.en  = busy && (step < pointPoolPkg::NUM_NEIGHBOR);
    assign featRd.idx = idxReg[step][pointPoolPkg::IDX_WIDTH-1:0];
    assign resVld     = busy && (step == pointPoolPkg::NUM_NEIGHBOR + 1);
    assign res        = acc;

    // Step 0..3 issue reads, 1..4 fold the returned words
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            step <= '0;
        end else if (taskVld && taskRdy) begin
            busy <= 1'b1;
            step <= '0;
        end else if (resVld && resRdy) begin
            busy <= 1'b0;
        end else if (busy && step <= pointPoolPkg::NUM_NEIGHBOR) begin
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (taskVld && taskRdy)
            idxReg <= taskDat;
        if (busy && step != '0 && step <= pointPoolPkg::NUM_NEIGHBOR) begin
            for (int l = 0; l < pointPoolPkg::NUM_LANE; l++) begin
                // First word seeds the maximum
                if (step == 1 || featRdDat[l] > acc[l])
                    acc[l] <= featRdDat[l];
            end
        end
    end

    // Four reads and the last fold put the result out 5 cycles after the accept
    assert property (@(posedge clk) disable iff (!arstN)
        taskVld && taskRdy |=> ##(pointPoolPkg::NUM_NEIGHBOR + 1) resVld);

endmodule

//--- source/resultCollector.sv
// Result drain
// Takes the core results in issue order and sends them out on the pad,
// last flag on the final task of the run

`timescale 1ns/1ns

module resultCollector (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic [pointPoolPkg::CNT_WIDTH-1:0] numTasks,
    input  pointPoolPkg::featWord_t            res [pointPoolPkg::POOL_CORE],
    input  logic [pointPoolPkg::POOL_CORE-1:0] resVld,
    output logic [pointPoolPkg::POOL_CORE-1:0] resRdy,
    output pointPoolPkg::padBeat_t             outBeat,
    output logic                               outVld,
    input  logic                               outRdy,
    output logic                               poolDone
);

    logic [pointPoolPkg::CORE_WIDTH-1:0] rdPtr;
    logic [pointPoolPkg::CNT_WIDTH-1:0]  outCnt;
    logic                                outXfer;

    // Only the core in turn sees the host ready
    assign outVld       = resVld[rdPtr];
    assign resRdy       = {{(pointPoolPkg::POOL_CORE - 1){1'b0}}, outRdy} << rdPtr;
    assign outBeat.dat  = res[rdPtr];
    assign outBeat.last = (outCnt == numTasks - 1'b1);
    assign outXfer      = outVld & outRdy;
    assign poolDone     = outXfer & outBeat.last;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdPtr  <= '0;
            outCnt <= '0;
        end else if (poolDone) begin
            rdPtr  <= '0;
            outCnt <= '0;
        end else if (outXfer) begin
            rdPtr  <= rdPtr + 1'b1;
            outCnt <= outCnt + 1'b1;
        end
    end

    // Host back-pressure must not disturb an offered beat
    assert property (@(posedge clk) disable iff (!arstN)
        outVld && !outRdy |=> outVld && $stable(outBeat));

endmodule

//--- source/runControl.sv
// Run sequencer
// Loads the feature and map frames from the pad, starts pooling,
// turns the pad around and ends the run with the finish pulse

`timescale 1ns/1ns

module runControl (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               startFire,
    input  pointPoolPkg::padBeat_t             inBeat,
    input  logic                               inVld,
    output logic                               inRdy,
    output logic                               datOE,
    output pointPoolPkg::bufWrite_t            bufWr,
    output logic [pointPoolPkg::CNT_WIDTH-1:0] numTasks,
    output logic                               poolGo,
    input  logic                               poolDone,
    output logic                               netFnh
);

    pointPoolPkg::runState_t              state;
    logic [pointPoolPkg::CNT_WIDTH-1:0]   wrCnt;
    logic                                 inXfer;

    assign inRdy  = (state == pointPoolPkg::LoadFeat) || (state == pointPoolPkg::LoadMap);
    assign inXfer = inVld & inRdy;
    assign datOE  = (state == pointPoolPkg::Pool);
    assign netFnh = (state == pointPoolPkg::Done);

    // Pad beats go straight into the buffer
    assign bufWr.en     = inXfer;
    assign bufWr.selMap = (state == pointPoolPkg::LoadMap);
    assign bufWr.addr   = wrCnt[pointPoolPkg::IDX_WIDTH-1:0];
    assign bufWr.dat    = inBeat.dat;

    // ================================================
    // Run FSM
    // ================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= pointPoolPkg::Idle;
            wrCnt    <= '0;
            numTasks <= '0;
            poolGo   <= 1'b0;
        end else begin
            poolGo <= 1'b0;
            case (state)
                pointPoolPkg::Idle: begin
                    if (startFire) begin
                        state <= pointPoolPkg::LoadFeat;
                        wrCnt <= '0;
                    end
                end
                pointPoolPkg::LoadFeat: begin
                    if (inXfer) begin
                        wrCnt <= inBeat.last ? '0 : wrCnt + 1'b1;
                        if (inBeat.last)
                            state <= pointPoolPkg::LoadMap;
                    end
                end
                pointPoolPkg::LoadMap: begin
                    if (inXfer) begin
                        wrCnt <= wrCnt + 1'b1;
                        if (inBeat.last) begin
                            state    <= pointPoolPkg::Pool;
                            numTasks <= wrCnt + 1'b1;
                            poolGo   <= 1'b1;
                        end
                    end
                end
                pointPoolPkg::Pool: begin
                    if (poolDone)
                        state <= pointPoolPkg::Done;
                end
                default: state <= pointPoolPkg::Idle;
            endcase
        end
    end

    // Host frames must fit the memories
    assert property (@(posedge clk) disable iff (!arstN)
        bufWr.en |-> wrCnt < (bufWr.selMap ? pointPoolPkg::MAP_DEPTH : pointPoolPkg::FEAT_DEPTH));

endmodule

//--- source/startDebounce.sv
// Start button filter
// Raw button in, one start pulse out on the falling edge of the steady level

`timescale 1ns/1ns

module startDebounce (
    input  logic clk,
    input  logic arstN,
    input  logic button,
    output logic startFire
);

    logic                               buttonSync;
    logic [pointPoolPkg::DEB_WIDTH-1:0] holdCnt;
    logic                               level;
    logic                               levelDly;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            buttonSync <= 1'b0;
            holdCnt    <= '0;
            level      <= 1'b0;
            levelDly   <= 1'b0;
        end else begin
            buttonSync <= button;
            levelDly   <= level;
            // Any bounce back to the current level restarts the hold time
            if (buttonSync == level) begin
                holdCnt <= '0;
            end else if (holdCnt == pointPoolPkg::DEB_WIDTH'(pointPoolPkg::DEBOUNCE_CYCLES - 1)) begin
                level   <= buttonSync;
                holdCnt <= '0;
            end else begin
                holdCnt <= holdCnt + 1'b1;
            end
        end
    end

    // Release of the button
    assign startFire = levelDly & ~level;

endmodule

//--- source/taskDispatcher.sv
// Task issue
// Reads the map words in order and offers each one to the cores in turn

`timescale 1ns/1ns

module taskDispatcher (
    input  logic                                    clk,
    input  logic                                    arstN,
    input  logic                                    poolGo,
    input  logic [pointPoolPkg::CNT_WIDTH-1:0]      numTasks,
    output logic                                    mapRdEn,
    output logic [pointPoolPkg::MAP_ADDR_WIDTH-1:0] mapRdAddr,
    input  pointPoolPkg::mapWord_t                  mapRdDat,
    output pointPoolPkg::mapWord_t                  taskDat,
    output logic [pointPoolPkg::POOL_CORE-1:0]      taskVld,
    input  logic [pointPoolPkg::POOL_CORE-1:0]      taskRdy
);

    logic [pointPoolPkg::CNT_WIDTH-1:0]  issued;
    logic [pointPoolPkg::CORE_WIDTH-1:0] corePtr;
    logic                                offer;
    logic                                accept;

    assign accept = offer & taskRdy[corePtr];

    // Next map read may overlap the accept of the current task
    assign mapRdEn   = ~poolGo & (~offer | accept) & (issued != numTasks);
    assign mapRdAddr = issued[pointPoolPkg::MAP_ADDR_WIDTH-1:0];

    // The buffer keeps the word until the next read
    assign taskDat = mapRdDat;
    assign taskVld = {{(pointPoolPkg::POOL_CORE - 1){1'b0}}, offer} << corePtr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issued  <= '0;
            corePtr <= '0;
            offer   <= 1'b0;
        end else if (poolGo) begin
            issued  <= '0;
            corePtr <= '0;
            offer   <= 1'b0;
        end else begin
            if (mapRdEn)
                issued <= issued + 1'b1;
            if (accept)
                corePtr <= corePtr + 1'b1;
            if (mapRdEn)
                offer <= 1'b1;
            else if (accept)
                offer <= 1'b0;
        end
    end

    // An offered task holds until its core takes it
    assert property (@(posedge clk) disable iff (!arstN)
        (|taskVld) && !accept |=> $stable(taskVld) && $stable(taskDat));

endmodule

//--- test/pointPoolStimulus.txt
# Columns: tag word. F feature word, M map word of four 8-bit indices, E expected result
# Bytes are lanes with lane 0 in bits 7:0. Each new block of F lines begins another run
F 10203040
F 0580017f
F ff004422
F 339a0281
M 03020100
M 01010000
M 82420200
E ff9a4481
E 1080307f
E ff204440
F 01020304
F 807ffe00
F 11ee22dd
M 02010002
M 00000000
E 80eefedd
E 01020304

//--- test/pointPoolTb.sv
// Testbench for the point pooling top level
// Replays the frames of test/pointPoolStimulus.txt over the pad bus, checks the
// pooled results, the last flag and the finish pulse under random host back-pressure

`timescale 1ns/1ns

module pointPoolTb;

    localparam int MAX_RUN  = 4;
    localparam int WAIT_MAX = 400;
    localparam int WIDTH    = pointPoolPkg::PORT_WIDTH;

    logic               clk;
    logic               arstN;
    logic               startPulse;
    wire  [WIDTH-1:0]   padDat;
    wire                padDatVld;
    wire                padDatLast;
    wire                padDatRdy;
    logic               datOE;
    logic               netFnh;

    // Host side of the pad
    pointPoolPkg::padBeat_t hostBeat;
    logic                   hostVld;
    logic                   hostRdy;

    logic [WIDTH-1:0] featWords [MAX_RUN][pointPoolPkg::FEAT_DEPTH];
    logic [WIDTH-1:0] mapWords  [MAX_RUN][pointPoolPkg::MAP_DEPTH];
    logic [WIDTH-1:0] expWords  [MAX_RUN][pointPoolPkg::MAP_DEPTH];
    int               featCnt   [MAX_RUN];
    int               mapCnt    [MAX_RUN];
    int               expCnt    [MAX_RUN];
    int               numRuns;
    int               errCnt;
    int               timeoutCnt;
    int               seedVal;
    logic             aborted;

    pointPoolTop dut (
        .clk        (clk),
        .arstN      (arstN),
        .startPulse (startPulse),
        .padDat     (padDat),
        .padDatVld  (padDatVld),
        .padDatLast (padDatLast),
        .padDatRdy  (padDatRdy),
        .datOE      (datOE),
        .netFnh     (netFnh)
    );

    // Host drives the pad only while the DUT is not driving it
    assign padDat     = datOE ? 'z   : hostBeat.dat;
    assign padDatVld  = datOE ? 1'bz : hostVld;
    assign padDatLast = datOE ? 1'bz : hostBeat.last;
    assign padDatRdy  = datOE ? hostRdy : 1'bz;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ================================================
    // Helpers
    // ================================================
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic readStimulus();
        int               fd;
        int               n;
        int               r;
        byte              tag;
        byte              prevTag;
        string            line;
        logic [WIDTH-1:0] val;
        fd = $fopen("test/pointPoolStimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errCnt++;
            aborted = 1'b1;
            return;
        end
        prevTag = "E";
        n = $fgets(line, fd);
        while (n > 0) begin
            if (line.getc(0) != "#" && $sscanf(line, "%c %h", tag, val) == 2) begin
                // A feature line after results opens the next run
                if (tag == "F" && prevTag != "F")
                    numRuns++;
                r = numRuns - 1;
                if (r >= 0 && r < MAX_RUN) begin
                    if (tag == "F") begin
                        featWords[r][featCnt[r]] = val;
                        featCnt[r]++;
                    end else if (tag == "M") begin
                        mapWords[r][mapCnt[r]] = val;
                        mapCnt[r]++;
                    end else if (tag == "E") begin
                        expWords[r][expCnt[r]] = val;
                        expCnt[r]++;
                    end
                end
                prevTag = tag;
            end
            n = $fgets(line, fd);
        end
        $fclose(fd);
        if (numRuns == 0 || numRuns > MAX_RUN) begin
            $display("the stimulus file holds no usable run");
            errCnt++;
            aborted = 1'b1;
        end
    endtask

    task automatic pressStart(input int len);
        nextCycle();
        startPulse = 1'b1;
        repeat (len) nextCycle();
        startPulse = 1'b0;
    endtask

    // Nothing may start or finish here
    task automatic watchIdle(input int len);
        repeat (len) begin
            @(negedge clk);
            if (padDatRdy !== 1'b0 || datOE !== 1'b0 || netFnh !== 1'b0) begin
                $display("error idle rdy/datOE/netFnh expected 0/0/0 actual %h/%h/%h",
                         padDatRdy, datOE, netFnh);
                errCnt++;
            end
        end
    endtask

    task automatic waitLoadReady();
        int k;
        if (aborted)
            return;
        for (k = 0; k < WAIT_MAX && padDatRdy !== 1'b1; k++)
            @(negedge clk);
        if (padDatRdy !== 1'b1) begin
            $display("timed out waiting for the run to start after the start press");
            timeoutCnt++;
            aborted = 1'b1;
        end
    endtask

    task automatic sendBeat(input logic [WIDTH-1:0] data, input logic last);
        int   k;
        logic taken;
        taken = 1'b0;
        nextCycle();
        hostBeat.dat  = data;
        hostBeat.last = last;
        hostVld       = 1'b1;
        for (k = 0; k < WAIT_MAX && !taken; k++) begin
            @(negedge clk);
            if (padDatRdy === 1'b1) begin
                taken = 1'b1;
            end else begin
                $display("error padDatRdy expected 1 actual %h", padDatRdy);
                errCnt++;
            end
        end
        if (!taken) begin
            $display("timed out sending a load beat");
            timeoutCnt++;
            aborted = 1'b1;
        end
    endtask

    task automatic sendFrame(input int run, input logic isMap);
        int i;
        int cnt;
        cnt = isMap ? mapCnt[run] : featCnt[run];
        for (i = 0; i < cnt && !aborted; i++) begin
            repeat ($urandom % 3) begin
                nextCycle();
                hostVld = 1'b0;
            end
            sendBeat(isMap ? mapWords[run][i] : featWords[run][i], i == cnt - 1);
        end
        nextCycle();
        hostVld = 1'b0;
    endtask

    task automatic receiveResults(input int run);
        int               idx;
        int               k;
        logic             held;
        logic [WIDTH-1:0] heldDat;
        idx  = 0;
        k    = 0;
        held = 1'b0;
        while (idx < expCnt[run] && k < WAIT_MAX && !aborted) begin
            nextCycle();
            hostRdy = ($urandom % 4) != 0;
            @(negedge clk);
            k++;
            if (datOE !== 1'b1 || netFnh !== 1'b0) begin
                $display("error datOE/netFnh expected 1/0 actual %h/%h", datOE, netFnh);
                errCnt++;
            end
            if (held && (padDatVld !== 1'b1 || padDat !== heldDat)) begin
                $display("a held result beat changed before it was taken");
                errCnt++;
            end
            held = 1'b0;
            if (padDatVld === 1'b1 && hostRdy) begin
                if (padDat !== expWords[run][idx]) begin
                    $display("error padDat expected %h actual %h", expWords[run][idx], padDat);
                    errCnt++;
                end
                if (padDatLast !== (idx == expCnt[run] - 1)) begin
                    $display("error padDatLast expected %h actual %h",
                             idx == expCnt[run] - 1, padDatLast);
                    errCnt++;
                end
                idx++;
                k = 0;
            end else if (padDatVld === 1'b1) begin
                held    = 1'b1;
                heldDat = padDat;
            end
        end
        if (idx < expCnt[run]) begin
            $display("timed out waiting for result %0d of run %0d", idx, run);
            timeoutCnt++;
            aborted = 1'b1;
        end
    endtask

    // Finish pulse one cycle after the final result, pad turned back to the host
    task automatic checkFinish();
        int extra;
        if (aborted)
            return;
        extra = 0;
        nextCycle();
        hostRdy = 1'b0;
        @(negedge clk);
        if (netFnh !== 1'b1 || datOE !== 1'b0) begin
            $display("error netFnh/datOE expected 1/0 actual %h/%h", netFnh, datOE);
            errCnt++;
        end
        repeat (8) begin
            @(negedge clk);
            if (netFnh !== 1'b0)
                extra++;
        end
        if (extra != 0) begin
            $display("netFnh stayed high or pulsed again after the run ended");
            errCnt++;
        end
    endtask

    task automatic runOnce(input int run);
        if (aborted)
            return;
        pressStart(12);
        waitLoadReady();
        if (!aborted)
            sendFrame(run, 1'b0);
        if (!aborted)
            sendFrame(run, 1'b1);
        receiveResults(run);
        checkFinish();
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        hostBeat   = '0;
        hostVld    = 1'b0;
        hostRdy    = 1'b0;
        startPulse = 1'b0;
        arstN      = 1'b0;
        errCnt     = 0;
        timeoutCnt = 0;
        numRuns    = 0;
        aborted    = 1'b0;
        for (int r = 0; r < MAX_RUN; r++) begin
            featCnt[r] = 0;
            mapCnt[r]  = 0;
            expCnt[r]  = 0;
        end
        seedVal = $urandom(32'h5bb7d632);
        readStimulus();
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;
        // A short glitch must not start a run
        watchIdle(4);
        pressStart(3);
        watchIdle(24);
        for (int r = 0; r < numRuns && !aborted; r++)
            runOnce(r);
        $display("runs %0d, errors %0d, timeouts %0d", numRuns, errCnt, timeoutCnt);
        if (errCnt == 0 && timeoutCnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
